//--- m26_pkg.sv
//********************
// Mimosa26 receiver shared definitions.
// Constants, register map, channel states and the packed
// word formats used between the receiver blocks.
//********************

package m26_pkg;

   localparam logic [7:0] M26_VERSION = 8'd1;
   localparam logic [7:0] M26_HEADER  = 8'h20;   // top byte of every output word.
   localparam logic [3:0] M26_IDENT   = 4'h1;

   localparam int M26_WORD_W    = 16;
   localparam int M26_MKD_LEN   = 4;           // marker bits that open a frame.
   localparam int M26_LANE_SKEW = 4;

   // upper bound on data words taken from the length word.
   localparam logic [10:0] M26_MAX_LEN = 11'd10;

   localparam int M26_FIFO_AW = 4;

   typedef enum logic [3:0] {
      ADDR_RST_VER = 4'd0,
      ADDR_CONF    = 4'd2,
      ADDR_LOST    = 4'd3
   } m26_reg_addr_e;

   typedef enum logic [2:0] {
      IDLE,
      HEADER,
      FRAME_CNT,
      LENGTH,
      DATA,
      TRAILER
   } m26_ch_state_e;

   typedef struct packed {
      logic ts_header;
      logic en;
   } m26_conf_t;

   typedef struct packed {
      logic                  frame_start;
      logic [M26_WORD_W-1:0] data;
   } m26_word_t;

   typedef struct packed {
      logic [7:0]            header;
      logic [3:0]            ident;
      logic [1:0]            zero;
      logic                  lost;          // a word was dropped before this one.
      logic                  frame_start;
      logic [M26_WORD_W-1:0] data;
   } m26_out_t;

endpackage

//--- m26_rx_regs.sv
//********************
// Mimosa26 receiver register block.
// Decodes the 8-bit bus into configuration bits and a
// soft reset pulse, and returns registered readback data.
//********************

`timescale 1ns/1ps

module m26_rx_regs import m26_pkg::*; (
   input  logic       CLK_RX,
   input  logic       RST_SYNC,
   input  logic [3:0] add,
   input  logic [7:0] data_in,
   input  logic       wr,
   input  logic       rd,
   input  logic [7:0] lost_cnt,
   output logic [7:0] data_out,
   output m26_conf_t  conf,
   output logic       soft_rst
);

   logic rst_wr;
   logic conf_wr;

   assign rst_wr  = wr && (add == ADDR_RST_VER);
   assign conf_wr = wr && (add == ADDR_CONF);

   always_ff @(posedge CLK_RX) begin
      if (RST_SYNC) begin
         soft_rst <= 1'b0;
      end else begin
         soft_rst <= rst_wr;   // one cycle pulse after the write.
      end
   end

   // the reset write also clears the configuration.
   always_ff @(posedge CLK_RX) begin
      if (RST_SYNC || rst_wr) begin
         conf <= '0;
      end else if (conf_wr) begin
         conf.en        <= data_in[0];
         conf.ts_header <= data_in[1];
      end
   end

   always_ff @(posedge CLK_RX) begin
      if (rd) begin
         case (add)
            ADDR_RST_VER: begin
               data_out <= M26_VERSION;
            end
            ADDR_CONF: begin
               data_out <= {6'b0, conf.ts_header, conf.en};
            end
            ADDR_LOST: begin
               data_out <= lost_cnt;
            end
            default: begin
               data_out <= 8'b0;
            end
         endcase
      end
   end

endmodule

//--- m26_rx_ch.sv
//********************
// Mimosa26 single lane deserializer.
// Finds the frame marker, cuts the serial stream into
// 16-bit words and follows the frame layout up to the
// trailer.
//********************

`timescale 1ns/1ps

module m26_rx_ch import m26_pkg::*; (
   input  logic      CLK_RX,
   input  logic      RST_SYNC,
   input  logic      mkd,
   input  logic      data,
   output logic      wr,
   output m26_word_t word
);

   m26_ch_state_e state;

   logic [M26_WORD_W-1:0]         sr;
   logic [M26_WORD_W-1:0]         sr_next;
   logic [$clog2(M26_WORD_W)-1:0] bit_cnt;
   logic [$clog2(M26_MKD_LEN):0]  mkd_cnt;
   logic                          mkd_found;
   logic                          word_done;
   logic [$bits(M26_MAX_LEN)-1:0] len_raw;
   logic [$bits(M26_MAX_LEN)-1:0] len;
   logic [$bits(M26_MAX_LEN)-1:0] word_cnt;

   assign sr_next   = {sr[M26_WORD_W-2:0], data};
   assign word_done = (bit_cnt == '1);
   assign len_raw   = sr_next[$bits(M26_MAX_LEN)-1:0];
   assign mkd_found = mkd && (mkd_cnt == M26_MKD_LEN[$clog2(M26_MKD_LEN):0] - 1'b1);

   always_ff @(posedge CLK_RX) begin
      sr <= sr_next;
   end

   // run length of the marker, held once it reaches the limit.
   always_ff @(posedge CLK_RX) begin
      if (RST_SYNC) begin
         mkd_cnt <= '0;
      end else if (!mkd) begin
         mkd_cnt <= '0;
      end else if (mkd_cnt != M26_MKD_LEN[$clog2(M26_MKD_LEN):0]) begin
         mkd_cnt <= mkd_cnt + 1'b1;
      end
   end

   always_ff @(posedge CLK_RX) begin
      if (RST_SYNC) begin
         state    <= IDLE;
         bit_cnt  <= '0;
         word_cnt <= '0;
         wr       <= 1'b0;
      end else begin
         wr <= 1'b0;
         if (mkd_found) begin
            state    <= HEADER;
            bit_cnt  <= M26_MKD_LEN[$clog2(M26_WORD_W)-1:0];   // next header bit.
            word_cnt <= '0;
         end else begin
            bit_cnt <= bit_cnt + 1'b1;
            if (word_done && state != IDLE) begin
               wr <= 1'b1;
               case (state)
                  HEADER: begin
                     state <= FRAME_CNT;
                  end
                  FRAME_CNT: begin
                     state <= LENGTH;
                  end
                  LENGTH: begin
                     word_cnt <= '0;
                     state    <= (len_raw == '0) ? TRAILER : DATA;
                  end
                  DATA: begin
                     if (word_cnt == len - 1'b1) begin
                        word_cnt <= '0;
                        state    <= TRAILER;
                     end else begin
                        word_cnt <= word_cnt + 1'b1;
                     end
                  end
                  TRAILER: begin
                     if (word_cnt == 1) begin
                        word_cnt <= '0;
                        state    <= IDLE;   // two trailer words done.
                     end else begin
                        word_cnt <= word_cnt + 1'b1;
                     end
                  end
                  default: begin
                     state <= IDLE;
                  end
               endcase
            end
         end
      end
   end

   always_ff @(posedge CLK_RX) begin
      if (word_done) begin
         word.data        <= sr_next;
         word.frame_start <= (state == HEADER);
      end
      if (word_done && state == LENGTH) begin
         len <= (len_raw > M26_MAX_LEN) ? M26_MAX_LEN : len_raw;
      end
   end

endmodule

//--- m26_rx_core.sv
//********************
// Mimosa26 receiver core.
// Samples both lanes, skews lane 1, deserializes each lane
// and merges the words into the packed output format with
// optional timestamp headers and loss accounting.
//********************

`timescale 1ns/1ps

module m26_rx_core import m26_pkg::*; (
   input  logic        CLK_RX,
   input  logic        RST_SYNC,
   input  logic        soft_rst,
   input  logic        mkd_rx,
   input  logic [1:0]  data_rx,
   input  logic [31:0] timestamp,
   input  m26_conf_t   conf,
   input  logic        full,
   output logic        wr_en,
   output m26_out_t    wdata,
   output logic [7:0]  lost_cnt,
   output logic        lost_error
);

   logic                   rst;
   logic [M26_LANE_SKEW:0] mkd_dly;
   logic [M26_LANE_SKEW:0] data1_dly;
   logic                   data0_q;
   logic [1:0]             ch_wr;
   m26_word_t              ch_word [2];
   m26_word_t              sel_word;
   logic [M26_WORD_W-1:0]  data_field;
   logic [31:0]            ts_save;
   logic                   lost_flag;

   assign rst = RST_SYNC | soft_rst;

   // index 0 is the input register, lane 1 taps the far end.
   always_ff @(posedge CLK_RX) begin
      mkd_dly   <= {mkd_dly[M26_LANE_SKEW-1:0], mkd_rx};
      data1_dly <= {data1_dly[M26_LANE_SKEW-1:0], data_rx[1]};
      data0_q   <= data_rx[0];
   end

   m26_rx_ch ch0 (
      .CLK_RX   (CLK_RX),
      .RST_SYNC (rst),
      .mkd      (mkd_dly[0]),
      .data     (data0_q),
      .wr       (ch_wr[0]),
      .word     (ch_word[0])
   );

   m26_rx_ch ch1 (
      .CLK_RX   (CLK_RX),
      .RST_SYNC (rst),
      .mkd      (mkd_dly[M26_LANE_SKEW]),
      .data     (data1_dly[M26_LANE_SKEW]),
      .wr       (ch_wr[1]),
      .word     (ch_word[1])
   );

   always_ff @(posedge CLK_RX) begin
      if (ch_wr[0] && ch_word[0].frame_start) begin
         ts_save <= timestamp;   // upper half goes out with lane 1.
      end
   end

   // lane 0 wins if both strobes ever meet.
   always_comb begin
      sel_word   = ch_wr[0] ? ch_word[0] : ch_word[1];
      data_field = sel_word.data;
      if (conf.ts_header && sel_word.frame_start) begin
         data_field = ch_wr[0] ? timestamp[15:0] : ts_save[31:16];
      end
   end

   assign wr_en = (|ch_wr) & conf.en;

   assign wdata.header      = M26_HEADER;
   assign wdata.ident       = M26_IDENT;
   assign wdata.zero        = 2'b0;
   assign wdata.lost        = lost_flag;
   assign wdata.frame_start = sel_word.frame_start;
   assign wdata.data        = data_field;

   always_ff @(posedge CLK_RX) begin
      if (rst) begin
         lost_cnt  <= 8'd0;
         lost_flag <= 1'b0;
      end else if (wr_en) begin
         lost_flag <= full;   // cleared by the next stored word.
         if (full && lost_cnt != 8'hff) begin
            lost_cnt <= lost_cnt + 8'd1;
         end
      end
   end

   assign lost_error = (lost_cnt != 8'd0);

endmodule

//--- m26_rx_fifo.sv
//********************
// Output FIFO for packed receiver words.
// First word fall through, single clock, writes to a
// full buffer are dropped.
//********************

`timescale 1ns/1ps

module m26_rx_fifo import m26_pkg::*; (
   input  logic     CLK_RX,
   input  logic     RST_SYNC,
   input  logic     soft_rst,
   input  logic     wr_en,
   input  m26_out_t wdata,
   input  logic     rd,
   output logic     full,
   output logic     empty,
   output m26_out_t rdata
);

   m26_out_t               mem [2**M26_FIFO_AW];
   logic [M26_FIFO_AW-1:0] wptr;
   logic [M26_FIFO_AW-1:0] rptr;
   logic [M26_FIFO_AW:0]   count;
   logic                   do_wr;
   logic                   do_rd;

   assign full  = (count == (M26_FIFO_AW+1)'(2**M26_FIFO_AW));
   assign empty = (count == '0);
   assign do_wr = wr_en && !full;
   assign do_rd = rd && !empty;

   assign rdata = mem[rptr];   // head entry.

   always_ff @(posedge CLK_RX) begin
      if (do_wr) begin
         mem[wptr] <= wdata;
      end
   end

   always_ff @(posedge CLK_RX) begin
      if (RST_SYNC || soft_rst) begin
         wptr  <= '0;
         rptr  <= '0;
         count <= '0;
      end else begin
         if (do_wr) begin
            wptr <= wptr + 1'b1;
         end
         if (do_rd) begin
            rptr <= rptr + 1'b1;
         end
         if (do_wr && !do_rd) begin
            count <= count + 1'b1;
         end else if (do_rd && !do_wr) begin
            count <= count - 1'b1;
         end
      end
   end

endmodule

//--- m26_rx_top.sv
//********************
// Mimosa26 receiver top level.
// Register block, receive core and output FIFO.
//********************

`timescale 1ns/1ps

module m26_rx_top import m26_pkg::*; (
   input  logic        CLK_RX,
   input  logic        RST_SYNC,
   input  logic        mkd_rx,
   input  logic [1:0]  data_rx,
   input  logic [31:0] timestamp,
   input  logic [3:0]  add,
   input  logic [7:0]  data_in,
   input  logic        wr,
   input  logic        rd,
   output logic [7:0]  data_out,
   input  logic        fifo_read,
   output logic        fifo_empty,
   output m26_out_t    fifo_data,
   output logic        lost_error
);

   m26_conf_t  conf;
   logic       soft_rst;
   logic [7:0] lost_cnt;
   logic       wr_en;
   m26_out_t   wdata;
   logic       full;

   m26_rx_regs regs0 (
      .CLK_RX   (CLK_RX),
      .RST_SYNC (RST_SYNC),
      .add      (add),
      .data_in  (data_in),
      .wr       (wr),
      .rd       (rd),
      .lost_cnt (lost_cnt),
      .data_out (data_out),
      .conf     (conf),
      .soft_rst (soft_rst)
   );

   m26_rx_core core0 (
      .CLK_RX     (CLK_RX),
      .RST_SYNC   (RST_SYNC),
      .soft_rst   (soft_rst),
      .mkd_rx     (mkd_rx),
      .data_rx    (data_rx),
      .timestamp  (timestamp),
      .conf       (conf),
      .full       (full),
      .wr_en      (wr_en),
      .wdata      (wdata),
      .lost_cnt   (lost_cnt),
      .lost_error (lost_error)
   );

   m26_rx_fifo fifo0 (
      .CLK_RX   (CLK_RX),
      .RST_SYNC (RST_SYNC),
      .soft_rst (soft_rst),
      .wr_en    (wr_en),
      .wdata    (wdata),
      .rd       (fifo_read),
      .full     (full),
      .empty    (fifo_empty),
      .rdata    (fifo_data)
   );

endmodule

//--- tb_m26_rx.sv
//********************
// Mimosa26 receiver testbench.
// Directed frames on both lanes, register access, length
// cap, timestamp headers and FIFO overflow with soft reset.
//********************

`timescale 1ns/1ps

module tb_m26_rx import m26_pkg::*; ();

   localparam int WORD_TIMEOUT = 64;    // cycles between two output words at most.
   localparam int QUIET_CYCLES = 64;
   localparam int POLL_LIMIT   = 40;

   logic        CLK_RX;
   logic        RST_SYNC;
   logic        mkd_rx;
   logic [1:0]  data_rx;
   logic [31:0] timestamp;
   logic [3:0]  add;
   logic [7:0]  data_in;
   logic        wr;
   logic        rd;
   logic [7:0]  data_out;
   logic        fifo_read;
   logic        fifo_empty;
   m26_out_t    fifo_data;
   logic        lost_error;

   integer      seed;
   logic [15:0] lane0_q [$];
   logic [15:0] lane1_q [$];
   m26_out_t    exp_q [$];

   m26_rx_top dut0 (
      .CLK_RX     (CLK_RX),
      .RST_SYNC   (RST_SYNC),
      .mkd_rx     (mkd_rx),
      .data_rx    (data_rx),
      .timestamp  (timestamp),
      .add        (add),
      .data_in    (data_in),
      .wr         (wr),
      .rd         (rd),
      .data_out   (data_out),
      .fifo_read  (fifo_read),
      .fifo_empty (fifo_empty),
      .fifo_data  (fifo_data),
      .lost_error (lost_error)
   );

   initial begin
      CLK_RX = 1'b0;
      forever #50 CLK_RX = ~CLK_RX;
   end

   task automatic check_val(input string what, input logic [31:0] got, input logic [31:0] exp);
      assert (got == exp) else begin
         $display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
         $display("FAIL: see errors above");
         $fatal(1, "value mismatch");
      end
   endtask

   task automatic timeout_fail(input string what);
      $display("timeout at %0t ns while waiting for %s", $time, what);
      $display("FAIL: see errors above");
      $fatal(1, "wait timed out");
   endtask

   task automatic reg_write(input logic [3:0] a, input logic [7:0] d);
      @(posedge CLK_RX);
      add     <= a;
      data_in <= d;
      wr      <= 1'b1;
      @(posedge CLK_RX);
      wr <= 1'b0;
   endtask

   task automatic reg_read(input logic [3:0] a, output logic [7:0] d);
      @(posedge CLK_RX);
      add <= a;
      rd  <= 1'b1;
      @(posedge CLK_RX);
      rd <= 1'b0;
      @(negedge CLK_RX);
      d = data_out;   // registered on the edge after rd.
   endtask

   // both lanes get random words, the length word carries len_field.
   task automatic build_frame(input logic [10:0] len_field, input logic ts_on,
                              input logic [31:0] ts);
      int          n_data;
      logic [15:0] w0;
      logic [15:0] w1;
      m26_out_t    e;
      lane0_q.delete();
      lane1_q.delete();
      exp_q.delete();
      n_data = (len_field > M26_MAX_LEN) ? int'(M26_MAX_LEN) : int'(len_field);
      for (int k = 0; k < n_data + 5; k++) begin
         w0 = 16'($random(seed));
         w1 = 16'($random(seed));
         if (k == 2) begin
            w0 = {w0[15:11], len_field};
            w1 = {w1[15:11], len_field};
         end
         lane0_q.push_back(w0);
         lane1_q.push_back(w1);
         e.header      = M26_HEADER;
         e.ident       = M26_IDENT;
         e.zero        = 2'b00;
         e.lost        = 1'b0;
         e.frame_start = (k == 0);
         e.data        = (ts_on && k == 0) ? ts[15:0] : w0;
         exp_q.push_back(e);
         e.data        = (ts_on && k == 0) ? ts[31:16] : w1;
         exp_q.push_back(e);
      end
   endtask

   task automatic send_lanes();
      for (int k = 0; k < lane0_q.size(); k++) begin
         for (int b = M26_WORD_W - 1; b >= 0; b--) begin
            @(posedge CLK_RX);
            mkd_rx  <= (k == 0) && (b >= M26_WORD_W - M26_MKD_LEN);
            data_rx <= {lane1_q[k][b], lane0_q[k][b]};   // msb first.
         end
      end
      @(posedge CLK_RX);
      mkd_rx  <= 1'b0;
      data_rx <= 2'b00;
   endtask

   task automatic expect_words(input int n);
      int wait_cnt;
      m26_out_t exp;
      for (int i = 0; i < n; i++) begin
         wait_cnt = 0;
         @(negedge CLK_RX);
         while (fifo_empty) begin
            wait_cnt++;
            if (wait_cnt > WORD_TIMEOUT) begin
               timeout_fail($sformatf("output word %0d", i));
            end
            @(negedge CLK_RX);
         end
         exp = exp_q.pop_front();
         check_val($sformatf("output word %0d", i), fifo_data, exp);
         @(posedge CLK_RX);
         fifo_read <= 1'b1;
         @(posedge CLK_RX);
         fifo_read <= 1'b0;
      end
   endtask

   task automatic expect_quiet(input int cycles);
      for (int i = 0; i < cycles; i++) begin
         @(negedge CLK_RX);
         check_val("fifo_empty while idle", 32'(fifo_empty), 32'd1);
      end
   endtask

   task automatic wait_lost(input logic [7:0] exp);
      logic [7:0] val;
      int tries;
      tries = 0;
      reg_read(ADDR_LOST, val);
      while (val != exp) begin
         tries++;
         if (tries > POLL_LIMIT) begin
            timeout_fail("the lost count to settle");
         end
         reg_read(ADDR_LOST, val);
      end
   endtask

   task automatic run_frame(input logic [10:0] len_field, input logic ts_on,
                            input logic [31:0] ts);
      int n;
      build_frame(len_field, ts_on, ts);
      n = exp_q.size();
      fork
         send_lanes();
         expect_words(n);
      join
   endtask

   task automatic test_registers();
      logic [7:0] val;
      reg_read(ADDR_RST_VER, val);
      check_val("version", 32'(val), 32'(M26_VERSION));
      reg_write(ADDR_CONF, 8'h03);
      reg_read(ADDR_CONF, val);
      check_val("conf readback", 32'(val), 32'h3);
      reg_read(ADDR_LOST, val);
      check_val("lost count", 32'(val), 32'd0);
      check_val("lost_error", 32'(lost_error), 32'd0);
      check_val("fifo_empty", 32'(fifo_empty), 32'd1);
   endtask

   task automatic test_basic_frame();
      reg_write(ADDR_CONF, 8'h01);
      run_frame(11'd3, 1'b0, 32'h0);   // 2 x (3 + 5) words.
      expect_quiet(QUIET_CYCLES);
   endtask

   task automatic test_length_cap();
      run_frame(11'd200, 1'b0, 32'h0);
      expect_quiet(QUIET_CYCLES);
   endtask

   task automatic test_disable();
      reg_write(ADDR_CONF, 8'h00);
      build_frame(11'd3, 1'b0, 32'h0);
      send_lanes();
      expect_quiet(QUIET_CYCLES);
      exp_q.delete();
   endtask

   task automatic test_timestamp();
      logic [31:0] ts;
      ts = $random(seed);
      @(posedge CLK_RX);
      timestamp <= ts;
      reg_write(ADDR_CONF, 8'h03);
      run_frame(11'd3, 1'b1, ts);
      expect_quiet(QUIET_CYCLES);
      reg_write(ADDR_CONF, 8'h01);
   endtask

   task automatic test_overflow();
      logic [7:0] val;
      int n_total;
      int exp_lost;
      int tries;
      reg_write(ADDR_CONF, 8'h01);
      build_frame(11'd10, 1'b0, 32'h0);
      n_total  = exp_q.size();
      exp_lost = n_total - 2**M26_FIFO_AW;
      if (exp_lost > 255) begin
         exp_lost = 255;
      end
      send_lanes();
      wait_lost(8'(exp_lost));
      repeat (QUIET_CYCLES) @(posedge CLK_RX);
      reg_read(ADDR_LOST, val);
      check_val("lost count after overflow", 32'(val), 32'(exp_lost));
      check_val("lost_error after overflow", 32'(lost_error), 32'd1);
      expect_words(2**M26_FIFO_AW - 1);   // the last stored entry stays behind.
      @(negedge CLK_RX);
      check_val("fifo_empty before soft reset", 32'(fifo_empty), 32'd0);
      check_val("last stored word", fifo_data, exp_q[0]);
      reg_write(ADDR_RST_VER, 8'h00);
      tries = 0;
      @(negedge CLK_RX);
      while (!fifo_empty) begin
         tries++;
         if (tries > 8) begin
            timeout_fail("fifo_empty after soft reset");
         end
         @(negedge CLK_RX);
      end
      reg_read(ADDR_LOST, val);
      check_val("lost count after soft reset", 32'(val), 32'd0);
      check_val("lost_error after soft reset", 32'(lost_error), 32'd0);
      reg_read(ADDR_CONF, val);
      check_val("conf after soft reset", 32'(val), 32'd0);
      exp_q.delete();
   endtask

   initial begin
      seed      = 32'h1d96_102d;
      RST_SYNC  = 1'b1;
      mkd_rx    = 1'b0;
      data_rx   = 2'b00;
      timestamp = 32'h0;
      add       = 4'h0;
      data_in   = 8'h00;
      wr        = 1'b0;
      rd        = 1'b0;
      fifo_read = 1'b0;
      repeat (10) @(posedge CLK_RX);
      RST_SYNC <= 1'b0;
      @(posedge CLK_RX);
      test_registers();
      test_basic_frame();
      test_length_cap();
      test_disable();
      test_timestamp();
      test_overflow();
      $display("PASS: all tests");
      $finish;
   end

endmodule

//--- list.f
m26_pkg.sv
m26_rx_regs.sv
m26_rx_ch.sv
m26_rx_core.sv
m26_rx_fifo.sv
m26_rx_top.sv
tb_m26_rx.sv

//--- Makefile
# Verilator build and run for the Mimosa26 receiver testbench.

VERILATOR ?= verilator
TOP       ?= tb_m26_rx
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= PASS: all tests

SRCS := $(filter %.sv %.v,$(shell cat $(FILELIST)))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qF "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
